//--- verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;
	localparam int clks_per_bit = 12; // 12 MHz clock gives 1 Mbaud
	localparam int cnt_w = $clog2(clks_per_bit);

	typedef logic [7:0] byte_t;
	typedef logic [cnt_w-1:0] bit_cnt_t; // counts clock cycles within one bit

	localparam bit_cnt_t bit_last = bit_cnt_t'(clks_per_bit - 1); // final cycle of a bit
	localparam bit_cnt_t half_last = bit_cnt_t'(clks_per_bit / 2 - 1); // middle of the start bit
endpackage

`default_nettype wire

//--- verilog/protocol_pkg.sv
`default_nettype none

package protocol_pkg;
	// framing characters of the command protocol
	localparam uart_pkg::byte_t start_char = 8'h01;
	localparam uart_pkg::byte_t end_char = 8'h17;
	localparam uart_pkg::byte_t escape_char = 8'h1B; // next byte is taken literally

	localparam logic [2:0] max_payload = 3'd6; // command byte, address and four data bytes

	typedef logic [6:0] periph_t;
	typedef logic [7:0] reg_addr_t;
	typedef logic [31:0] reg_data_t;
	typedef logic [2:0] reg_size_t; // reply size in bytes

	localparam periph_t scratch_periph = 7'd1;
	localparam reg_size_t scratch_size = 3'd4;
endpackage

`default_nettype wire

//--- verilog/uart_rx.sv
`default_nettype none

module uart_rx (
	input wire clk_12MHz,
	input wire reset,
	input wire rx,
	output uart_pkg::byte_t rx_byte,
	output logic rx_valid
);
	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

	rx_state_t state;
	logic [1:0] rx_sync;
	uart_pkg::bit_cnt_t bit_cnt;
	logic [2:0] bit_idx;
	uart_pkg::byte_t shift;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			rx_sync <= 2'b11; // idle line is high
			state <= rx_idle;
			bit_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_sync <= {rx_sync[0], rx}; // bit 1 is the synchronised line
			rx_valid <= 1'b0;
			case (state)
				rx_idle:
					if (!rx_sync[1])
					begin
						state <= rx_start;
						bit_cnt <= '0;
					end
				rx_start:
					if (bit_cnt == uart_pkg::half_last)
					begin
						bit_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync[1] ? rx_idle : rx_data; // a short glitch is no start bit
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				rx_data:
					if (bit_cnt == uart_pkg::bit_last)
					begin
						bit_cnt <= '0;
						shift <= {rx_sync[1], shift[7:1]}; // data arrives lsb first
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				rx_stop:
					if (bit_cnt == uart_pkg::bit_last)
					begin
						rx_valid <= rx_sync[1]; // framing error drops the byte
						rx_byte <= shift;
						state <= rx_idle;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				default:
					state <= rx_idle;
			endcase
		end
	end

	// consumers count bytes by pulses, so a stretched pulse would duplicate one
	assert property (@(posedge clk_12MHz) disable iff (reset) rx_valid |=> !rx_valid);
endmodule

`default_nettype wire

//--- verilog/frame_decoder.sv
`default_nettype none

module frame_decoder (
	input wire clk_12MHz,
	input wire reset,
	input wire uart_pkg::byte_t rx_byte,
	input wire rx_valid,
	input wire cmd_busy,
	output logic cmd_valid,
	output logic cmd_read,
	output protocol_pkg::periph_t cmd_periph,
	output protocol_pkg::reg_addr_t cmd_addr,
	output protocol_pkg::reg_data_t cmd_wdata
);
	uart_pkg::byte_t buffer [protocol_pkg::max_payload];
	logic [2:0] count;
	logic in_frame;
	logic escape;
	logic is_start;
	logic is_end;
	logic is_escape;
	logic special;
	logic clear_buf;
	logic store_byte;

	always_comb
	begin
		is_start = rx_byte == protocol_pkg::start_char;
		is_end = rx_byte == protocol_pkg::end_char;
		is_escape = rx_byte == protocol_pkg::escape_char;
		special = !escape && (is_start || is_end || is_escape); // escaped bytes are plain data
		clear_buf = rx_valid && is_start && !escape; // a start restarts the frame at any time
		store_byte = rx_valid && in_frame && !special && count < protocol_pkg::max_payload;
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			in_frame <= 1'b0;
			escape <= 1'b0;
			count <= '0;
			cmd_valid <= 1'b0;
		end
		else
		begin
			cmd_valid <= 1'b0;
			if (clear_buf)
			begin
				in_frame <= 1'b1;
				count <= '0;
			end
			else if (rx_valid && in_frame && special && is_end)
			begin
				in_frame <= 1'b0;
				cmd_valid <= count > 3'd1 && !cmd_busy; // needs at least command byte and address
			end
			else if (rx_valid && in_frame && special)
				escape <= 1'b1;
			else if (rx_valid && in_frame)
			begin
				escape <= 1'b0;
				if (store_byte)
					count <= count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (clear_buf)
			buffer <= '{default: '0}; // missing data bytes read as zero
		else if (store_byte)
			buffer[count] <= rx_byte;
	end

	assign cmd_read = buffer[0][7];
	assign cmd_periph = buffer[0][6:0];
	assign cmd_addr = buffer[1];
	assign cmd_wdata = {buffer[5], buffer[4], buffer[3], buffer[2]}; // least significant byte first

	assert property (@(posedge clk_12MHz) disable iff (reset)
		count <= protocol_pkg::max_payload);
endmodule

`default_nettype wire

//--- verilog/bus_master.sv
`default_nettype none

module bus_master (
	input wire clk_12MHz,
	input wire reset,
	input wire cmd_valid,
	input wire cmd_read,
	input wire protocol_pkg::periph_t cmd_periph,
	input wire protocol_pkg::reg_addr_t cmd_addr,
	input wire protocol_pkg::reg_data_t cmd_wdata,
	output logic cmd_busy,
	output protocol_pkg::reg_addr_t bus_addr,
	output protocol_pkg::reg_data_t bus_wdata,
	output logic wr_strobe,
	output logic rd_strobe,
	input wire protocol_pkg::reg_data_t bank_rdata,
	input wire enc_busy,
	output logic reply_valid,
	output uart_pkg::byte_t reply_periph_byte,
	output protocol_pkg::reg_addr_t reply_addr,
	output protocol_pkg::reg_data_t reply_data,
	output protocol_pkg::reg_size_t reply_size
);
	typedef enum logic [2:0] {bm_idle, bm_write, bm_read, bm_reply, bm_drain} bm_state_t;

	bm_state_t state;
	logic cmd_hit;
	logic hit;

	assign cmd_hit = cmd_periph == protocol_pkg::scratch_periph;
	assign cmd_busy = state != bm_idle;
	assign reply_addr = bus_addr;
	assign reply_data = hit ? bank_rdata : '0; // every other peripheral reads as zero
	assign reply_size = hit ? protocol_pkg::scratch_size : '0;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= bm_idle;
			wr_strobe <= 1'b0;
			rd_strobe <= 1'b0;
			reply_valid <= 1'b0;
		end
		else
		begin
			wr_strobe <= 1'b0;
			rd_strobe <= 1'b0;
			reply_valid <= 1'b0;
			case (state)
				bm_idle:
					if (cmd_valid)
					begin
						if (cmd_read)
						begin
							rd_strobe <= cmd_hit;
							state <= bm_read;
						end
						else
						begin
							wr_strobe <= cmd_hit;
							state <= bm_write;
						end
					end
				bm_write:
				begin
					rd_strobe <= hit; // read back the value just written
					state <= bm_read;
				end
				bm_read:
				begin
					reply_valid <= 1'b1; // bank_rdata is settled from the next cycle on
					state <= bm_reply;
				end
				bm_reply:
					state <= bm_drain; // encoder raises enc_busy at the end of this cycle
				bm_drain:
					if (!enc_busy)
						state <= bm_idle;
				default:
					state <= bm_idle;
			endcase
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (cmd_valid)
		begin
			hit <= cmd_hit;
			bus_addr <= cmd_addr;
			bus_wdata <= cmd_wdata;
			reply_periph_byte <= {cmd_read, cmd_periph}; // echo the original command byte
		end
	end

	assert property (@(posedge clk_12MHz) disable iff (reset) !(wr_strobe && rd_strobe));
endmodule

`default_nettype wire

//--- verilog/register_bank.sv
`default_nettype none

module register_bank (
	input wire clk_12MHz,
	input wire reset,
	input wire protocol_pkg::reg_addr_t bus_addr,
	input wire protocol_pkg::reg_data_t bus_wdata,
	input wire wr_strobe,
	input wire rd_strobe,
	output protocol_pkg::reg_data_t bank_rdata
);
	protocol_pkg::reg_data_t regs [4];
	logic [1:0] index;

	assign index = bus_addr[1:0]; // upper address bits alias onto the four registers

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
			regs <= '{default: '0};
		else if (wr_strobe)
			regs[index] <= bus_wdata;
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (rd_strobe)
			bank_rdata <= regs[index]; // held until the next read
	end
endmodule

`default_nettype wire

//--- verilog/reply_encoder.sv
`default_nettype none

module reply_encoder (
	input wire clk_12MHz,
	input wire reset,
	input wire reply_valid,
	input wire uart_pkg::byte_t reply_periph_byte,
	input wire protocol_pkg::reg_addr_t reply_addr,
	input wire protocol_pkg::reg_data_t reply_data,
	input wire protocol_pkg::reg_size_t reply_size,
	output logic enc_busy,
	output uart_pkg::byte_t tx_byte,
	output logic tx_start,
	input wire tx_busy
);
	typedef enum logic [1:0] {enc_idle, enc_send, enc_flush} enc_state_t;

	enc_state_t state;
	uart_pkg::byte_t periph_q;
	protocol_pkg::reg_addr_t addr_q;
	protocol_pkg::reg_data_t data_q;
	logic [3:0] last_pos;
	logic [3:0] pos;
	logic [3:0] data_idx;
	logic esc_done;
	uart_pkg::byte_t cur_byte;
	logic framing;
	logic need_esc;
	logic send_now;
	logic send_esc;

	// pos 0 is the start character, 1 the command byte, 2 the address, then data, then end
	always_comb
	begin
		data_idx = pos - 4'd3;
		framing = pos == 4'd0 || pos == last_pos;
		if (pos == 4'd0)
			cur_byte = protocol_pkg::start_char;
		else if (pos == last_pos)
			cur_byte = protocol_pkg::end_char;
		else if (pos == 4'd1)
			cur_byte = periph_q;
		else if (pos == 4'd2)
			cur_byte = addr_q;
		else
			cur_byte = data_q[{data_idx[1:0], 3'b000} +: 8];
		need_esc = !framing && (cur_byte == protocol_pkg::start_char
			|| cur_byte == protocol_pkg::end_char || cur_byte == protocol_pkg::escape_char);
		send_now = state == enc_send && !tx_busy && !tx_start; // tx_busy lags tx_start by a cycle
		send_esc = need_esc && !esc_done;
	end

	assign enc_busy = state != enc_idle;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= enc_idle;
			tx_start <= 1'b0;
			pos <= '0;
			esc_done <= 1'b0;
		end
		else
		begin
			tx_start <= send_now;
			case (state)
				enc_idle:
					if (reply_valid)
					begin
						state <= enc_send;
						pos <= '0;
						esc_done <= 1'b0;
					end
				enc_send:
					if (send_now && send_esc)
						esc_done <= 1'b1; // the byte itself follows the escape
					else if (send_now)
					begin
						esc_done <= 1'b0;
						if (pos == last_pos)
							state <= enc_flush;
						else
							pos <= pos + 1'b1;
					end
				enc_flush:
					if (!tx_busy && !tx_start)
						state <= enc_idle; // end character has left the line
				default:
					state <= enc_idle;
			endcase
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (state == enc_idle && reply_valid)
		begin
			periph_q <= reply_periph_byte;
			addr_q <= reply_addr;
			data_q <= reply_data;
			last_pos <= {1'b0, reply_size} + 4'd3;
		end
		if (send_now)
			tx_byte <= send_esc ? protocol_pkg::escape_char : cur_byte;
	end

	// a start while the transmitter is busy would be lost
	assert property (@(posedge clk_12MHz) disable iff (reset) tx_start |-> !tx_busy);
endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`default_nettype none

module uart_tx (
	input wire clk_12MHz,
	input wire reset,
	input wire uart_pkg::byte_t tx_byte,
	input wire tx_start,
	output logic tx_busy,
	output logic tx
);
	uart_pkg::bit_cnt_t bit_cnt;
	logic [3:0] bit_idx;
	logic [8:0] shift;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			bit_cnt <= '0;
			bit_idx <= '0;
		end
		else if (!tx_busy)
		begin
			if (tx_start)
			begin
				tx <= 1'b0; // start bit
				shift <= {1'b1, tx_byte}; // stop bit sits above the data
				bit_cnt <= '0;
				bit_idx <= '0;
				tx_busy <= 1'b1;
			end
		end
		else if (bit_cnt != uart_pkg::bit_last)
			bit_cnt <= bit_cnt + 1'b1;
		else
		begin
			bit_cnt <= '0;
			if (bit_idx == 4'd9)
				tx_busy <= 1'b0; // stop bit is complete
			else
			begin
				tx <= shift[0]; // lsb first
				shift <= {1'b1, shift[8:1]};
				bit_idx <= bit_idx + 1'b1;
			end
		end
	end
endmodule

`default_nettype wire

//--- verilog/uniboard_top.sv
`default_nettype none

module uniboard_top (
	input wire clk_12MHz,
	input wire reset,
	input wire uart_rx,
	output logic uart_tx
);
	uart_pkg::byte_t rx_byte;
	logic rx_valid;
	logic cmd_valid;
	logic cmd_read;
	protocol_pkg::periph_t cmd_periph;
	protocol_pkg::reg_addr_t cmd_addr;
	protocol_pkg::reg_data_t cmd_wdata;
	logic cmd_busy;
	protocol_pkg::reg_addr_t bus_addr;
	protocol_pkg::reg_data_t bus_wdata;
	logic wr_strobe;
	logic rd_strobe;
	protocol_pkg::reg_data_t bank_rdata;
	logic enc_busy;
	logic reply_valid;
	uart_pkg::byte_t reply_periph_byte;
	protocol_pkg::reg_addr_t reply_addr;
	protocol_pkg::reg_data_t reply_data;
	protocol_pkg::reg_size_t reply_size;
	uart_pkg::byte_t tx_byte;
	logic tx_start;
	logic tx_busy;

	uart_rx u_rx (.clk_12MHz(clk_12MHz), .reset(reset), .rx(uart_rx),
		.rx_byte(rx_byte), .rx_valid(rx_valid));

	frame_decoder u_decoder (.clk_12MHz(clk_12MHz), .reset(reset),
		.rx_byte(rx_byte), .rx_valid(rx_valid), .cmd_busy(cmd_busy),
		.cmd_valid(cmd_valid), .cmd_read(cmd_read), .cmd_periph(cmd_periph),
		.cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata));

	bus_master u_master (.clk_12MHz(clk_12MHz), .reset(reset),
		.cmd_valid(cmd_valid), .cmd_read(cmd_read), .cmd_periph(cmd_periph),
		.cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .cmd_busy(cmd_busy),
		.bus_addr(bus_addr), .bus_wdata(bus_wdata), .wr_strobe(wr_strobe),
		.rd_strobe(rd_strobe), .bank_rdata(bank_rdata), .enc_busy(enc_busy),
		.reply_valid(reply_valid), .reply_periph_byte(reply_periph_byte),
		.reply_addr(reply_addr), .reply_data(reply_data), .reply_size(reply_size));

	register_bank u_bank (.clk_12MHz(clk_12MHz), .reset(reset),
		.bus_addr(bus_addr), .bus_wdata(bus_wdata), .wr_strobe(wr_strobe),
		.rd_strobe(rd_strobe), .bank_rdata(bank_rdata));

	reply_encoder u_encoder (.clk_12MHz(clk_12MHz), .reset(reset),
		.reply_valid(reply_valid), .reply_periph_byte(reply_periph_byte),
		.reply_addr(reply_addr), .reply_data(reply_data), .reply_size(reply_size),
		.enc_busy(enc_busy), .tx_byte(tx_byte), .tx_start(tx_start), .tx_busy(tx_busy));

	uart_tx u_tx (.clk_12MHz(clk_12MHz), .reset(reset), .tx_byte(tx_byte),
		.tx_start(tx_start), .tx_busy(tx_busy), .tx(uart_tx));
endmodule

`default_nettype wire

//--- verification/tb_uniboard.sv
`default_nettype none

module tb_uniboard;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int bit_cycles = uart_pkg::clks_per_bit;
	localparam int first_byte_limit = 2000; // cycles allowed before a reply starts
	localparam int next_byte_limit = 100; // cycles allowed between two reply bytes
	localparam int quiet_window = 300;

	logic clk_12MHz;
	logic reset;
	logic rx_line;
	wire tx_line;
	logic [15:0] lfsr_state;
	protocol_pkg::reg_data_t model_regs [4];
	int checks;
	int errors;
	bit timed_out;

	uniboard_top u_dut (.clk_12MHz(clk_12MHz), .reset(reset), .uart_rx(rx_line),
		.uart_tx(tx_line));

	always #2 clk_12MHz = !clk_12MHz;

	// taps of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state); // one step for every bit taken
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic bit is_special(input uart_pkg::byte_t b);
		return b == protocol_pkg::start_char || b == protocol_pkg::end_char
			|| b == protocol_pkg::escape_char;
	endfunction

	// every byte is a framing character or random, the lowest one always a framing character
	function automatic protocol_pkg::reg_data_t special_value();
		protocol_pkg::reg_data_t value;
		uart_pkg::byte_t specials [3];
		logic [1:0] sel;
		specials = '{protocol_pkg::start_char, protocol_pkg::end_char, protocol_pkg::escape_char};
		for (int i = 0; i < 4; i++)
		begin
			sel = random_bits(2);
			value[8*i +: 8] = (sel == 2'd3) ? random_bits(8) : specials[sel];
		end
		value[7:0] = specials[random_bits(2) % 3];
		return value;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		assert (got === expected)
		else
		begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic check_true(input bit condition, input string what);
		checks++;
		assert (condition)
		else
		begin
			$display("at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	// called on a rising edge plus 1 ns, returns at the same phase
	task automatic send_serial(input uart_pkg::byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0}; // stop, data lsb first, start
		for (int i = 0; i < 10; i++)
		begin
			rx_line = bits[i];
			repeat (bit_cycles) @(posedge clk_12MHz);
			#1;
		end
	endtask

	task automatic send_frame(input uart_pkg::byte_t payload [$]);
		@(posedge clk_12MHz);
		#1;
		send_serial(protocol_pkg::start_char);
		foreach (payload[i])
		begin
			if (is_special(payload[i]))
				send_serial(protocol_pkg::escape_char);
			send_serial(payload[i]);
		end
		send_serial(protocol_pkg::end_char);
	endtask

	// uart_tx changes on rising edges, so it is sampled on falling ones
	task automatic receive_byte(input int limit, output uart_pkg::byte_t value, output bit seen);
		int waited;
		waited = 0;
		seen = 1'b0;
		value = '0;
		while (tx_line !== 1'b0 && waited < limit)
		begin
			@(negedge clk_12MHz);
			waited++;
		end
		if (tx_line === 1'b0)
		begin
			seen = 1'b1;
			repeat (bit_cycles / 2) @(negedge clk_12MHz); // middle of the start bit
			for (int i = 0; i < 8; i++)
			begin
				repeat (bit_cycles) @(negedge clk_12MHz);
				value[i] = tx_line;
			end
			repeat (bit_cycles) @(negedge clk_12MHz);
			check_value("uart_tx stop bit", tx_line, 1'b1);
		end
	endtask

	task automatic receive_reply(output uart_pkg::byte_t raw [$], output uart_pkg::byte_t body [$]);
		uart_pkg::byte_t value;
		bit seen;
		bit escaped;
		bit done;
		raw = {};
		body = {};
		escaped = 1'b0;
		receive_byte(first_byte_limit, value, seen);
		if (seen)
			raw.push_back(value); // should be the start character
		else
		begin
			$display("at %0t ns: no reply arrived on uart_tx before the timeout", $time);
			timed_out = 1'b1;
			errors++;
		end
		done = !seen;
		while (!done && raw.size() < 32)
		begin
			receive_byte(next_byte_limit, value, seen);
			if (!seen)
			begin
				$display("at %0t ns: reply stopped before its end character", $time);
				timed_out = 1'b1;
				errors++;
				done = 1'b1;
			end
			else
			begin
				raw.push_back(value);
				if (escaped)
				begin
					body.push_back(value);
					escaped = 1'b0;
				end
				else if (value == protocol_pkg::escape_char)
					escaped = 1'b1;
				else if (value == protocol_pkg::end_char)
					done = 1'b1;
				else
					body.push_back(value);
			end
		end
	endtask

	task automatic exchange(input uart_pkg::byte_t payload [$], input uart_pkg::byte_t expected [$]);
		uart_pkg::byte_t raw [$];
		uart_pkg::byte_t body [$];
		uart_pkg::byte_t framed [$];
		if (!timed_out)
		begin
			send_frame(payload);
			receive_reply(raw, body);
		end
		if (!timed_out)
		begin
			framed.push_back(protocol_pkg::start_char);
			foreach (expected[i])
			begin
				if (is_special(expected[i]))
					framed.push_back(protocol_pkg::escape_char);
				framed.push_back(expected[i]);
			end
			framed.push_back(protocol_pkg::end_char);
			check_value("reply length", body.size(), expected.size());
			check_value("raw uart_tx length", raw.size(), framed.size());
			foreach (expected[i])
				if (i < body.size())
					check_value($sformatf("reply byte %0d", i), body[i], expected[i]);
			foreach (framed[i])
				if (i < raw.size())
					check_value($sformatf("raw uart_tx byte %0d", i), raw[i], framed[i]);
		end
	endtask

	task automatic write_command(input protocol_pkg::periph_t periph,
		input protocol_pkg::reg_addr_t addr, input int data_bytes,
		input protocol_pkg::reg_data_t value);
		uart_pkg::byte_t payload [$];
		uart_pkg::byte_t expected [$];
		protocol_pkg::reg_data_t stored;
		stored = '0; // bytes left out of the frame arrive as zero
		payload.push_back({1'b0, periph});
		payload.push_back(addr);
		expected = payload;
		for (int i = 0; i < data_bytes; i++)
		begin
			payload.push_back(value[8*i +: 8]);
			stored[8*i +: 8] = value[8*i +: 8];
		end
		if (periph == protocol_pkg::scratch_periph)
		begin
			model_regs[addr[1:0]] = stored;
			for (int i = 0; i < protocol_pkg::scratch_size; i++)
				expected.push_back(stored[8*i +: 8]);
		end
		exchange(payload, expected);
	endtask

	task automatic read_command(input protocol_pkg::periph_t periph,
		input protocol_pkg::reg_addr_t addr);
		uart_pkg::byte_t payload [$];
		uart_pkg::byte_t expected [$];
		payload.push_back({1'b1, periph});
		payload.push_back(addr);
		expected = payload;
		if (periph == protocol_pkg::scratch_periph)
			for (int i = 0; i < protocol_pkg::scratch_size; i++)
				expected.push_back(model_regs[addr[1:0]][8*i +: 8]);
		exchange(payload, expected);
	endtask

	task automatic report_test(input int number, input string name, input int errors_before);
		$display("test %0d %s: %0d errors", number, name, errors - errors_before);
	endtask

	initial
	begin
		uart_pkg::byte_t value;
		uart_pkg::byte_t short_frame [$];
		bit seen;
		int errors_before;
		protocol_pkg::periph_t periph;
		protocol_pkg::reg_addr_t addr;
		clk_12MHz = 1'b0;
		reset = 1'b1;
		rx_line = 1'b1; // idle line
		lfsr_state = 16'd27;
		checks = 0;
		errors = 0;
		timed_out = 1'b0;
		model_regs = '{default: '0};
		repeat (8) @(posedge clk_12MHz);
		#1;
		reset = 1'b0;

		errors_before = errors;
		receive_byte(200, value, seen);
		check_true(!seen, "uart_tx sent a byte after reset");
		check_value("uart_tx", tx_line, 1'b1);
		report_test(1, "idle after reset", errors_before);

		errors_before = errors;
		for (int i = 0; i < 12; i++)
			write_command(protocol_pkg::scratch_periph, random_bits(8), random_bits(3) % 5,
				random_bits(32));
		report_test(2, "random writes", errors_before);

		errors_before = errors;
		for (int i = 0; i < 8; i++)
			read_command(protocol_pkg::scratch_periph, random_bits(8));
		report_test(3, "random reads", errors_before);

		errors_before = errors;
		for (int i = 0; i < 6; i++)
		begin
			periph = random_bits(7);
			if (periph == protocol_pkg::scratch_periph)
				periph = 7'h7F;
			if (random_bits(1))
				write_command(periph, random_bits(8), 4, random_bits(32));
			else
				read_command(periph, random_bits(8));
		end
		report_test(4, "other peripherals", errors_before);

		errors_before = errors;
		for (int i = 0; i < 6; i++)
		begin
			addr = random_bits(8);
			write_command(protocol_pkg::scratch_periph, addr, 4, special_value());
			read_command(protocol_pkg::scratch_periph, addr);
		end
		report_test(5, "escaped values", errors_before);

		errors_before = errors;
		@(posedge clk_12MHz);
		#1;
		for (int i = 0; i < 3; i++)
		begin
			value = random_bits(8);
			if (value == protocol_pkg::start_char)
				value = 8'h00;
			send_serial(value); // no frame is open yet
		end
		short_frame.push_back(random_bits(8));
		send_frame(short_frame);
		receive_byte(quiet_window, value, seen);
		check_true(!seen, "uart_tx answered a stray byte or a one-byte frame");
		read_command(protocol_pkg::scratch_periph, random_bits(8));
		report_test(6, "dropped frames", errors_before);

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end
endmodule

`default_nettype wire

//--- list.f
verilog/uart_pkg.sv
verilog/protocol_pkg.sv
verilog/uart_rx.sv
verilog/frame_decoder.sv
verilog/bus_master.sv
verilog/register_bank.sv
verilog/reply_encoder.sv
verilog/uart_tx.sv
verilog/uniboard_top.sv
verification/tb_uniboard.sv

//--- Bender.yml
package:
  name: uniboard_bridge

sources:
  - verilog/uart_pkg.sv
  - verilog/protocol_pkg.sv
  - verilog/uart_rx.sv
  - verilog/frame_decoder.sv
  - verilog/bus_master.sv
  - verilog/register_bank.sv
  - verilog/reply_encoder.sv
  - verilog/uart_tx.sv
  - verilog/uniboard_top.sv
  - target: test
    files:
      - verification/tb_uniboard.sv
